//--- verilog.f
+incdir+.
iopmp_pkg.sv
iopmp_csr_regs.sv
iopmp_entry_match.sv
iopmp_port_check.sv
iopmp_memory_domain.sv
iopmp_props.sv
tb_iopmp_memory_domain.sv

//--- run.sh
#!/bin/sh
# Build and run the IOPMP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_iopmp_memory_domain -f verilog.f -o sim_iopmp > sim.log 2>&1 \
  && ./obj_dir/sim_iopmp +verilator+error+limit+1000 >> sim.log 2>&1 \
  || echo "Build or simulation ended with an error status" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL: no result"; exit 1; }
echo "PASS"

//--- tb_iopmp_memory_domain.sv
// IOPMP memory domain testbench
`include "iopmp_settings.svh"

module tb_iopmp_memory_domain;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int NUM_ACCESSES   = 200;

  logic                   cpuclk = 1'b0;
  logic                   rst_n;
  logic                   memory_domain_selected;
  iopmp_pkg::csr_addr_t   csr_sel;
  logic                   csr_wen;
  logic [`IOPMP_XLEN-1:0] csr_wdata;
  logic [`IOPMP_XLEN-1:0] csr_rdata;
  logic [`IOPMP_XLEN-1:0] addr_0;
  logic                   write_0;
  logic                   deny_0;
  logic [`IOPMP_XLEN-1:0] addr_1;
  logic                   write_1;
  logic                   deny_1;

  integer      seed        = 32'hae6b;
  int          test_errors = 0;
  int          errors      = 0;
  int          tests_run   = 0;
  int          tests_bad   = 0;
  int          checks      = 0;
  int          prop_seen   = 0;
  logic [7:0]  shadow_cfg  [`IOPMP_ENTRIES];  // Expected register contents
  logic [29:0] shadow_addr [`IOPMP_ENTRIES];
  logic [31:0] edges  [10] = '{32'h0, 32'h1000, 32'h1004, 32'h1800, 32'h2000,
                               32'h8000_0000, 32'h8001_0000, 32'h9000_0000,
                               32'hC000_0000, 32'hC001_0000};
  logic [31:0] misses [6]  = '{32'h0, 32'hFFC, 32'h2000, 32'h4000_0000,
                               32'hC001_0000, 32'hF000_0000};

  iopmp_memory_domain UUT (
    .cpuclk                 (cpuclk                ),
    .rst_n                  (rst_n                 ),
    .memory_domain_selected (memory_domain_selected),
    .csr_sel                (csr_sel               ),
    .csr_wen                (csr_wen               ),
    .csr_wdata              (csr_wdata             ),
    .csr_rdata              (csr_rdata             ),
    .addr_0                 (addr_0                ),
    .write_0                (write_0               ),
    .deny_0                 (deny_0                ),
    .addr_1                 (addr_1                ),
    .write_1                (write_1               ),
    .deny_1                 (deny_1                )
  );

  always #5 cpuclk = ~cpuclk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic iopmp_pkg::csr_addr_t pmpaddr_sel(int n);
    return iopmp_pkg::csr_addr_t'(`IOPMP_CSR_PMPADDR0 + 4 * n);
  endfunction

  // First matching entry decides
  function automatic logic predict_deny(logic [31:0] acc, logic wr, logic sel);
    logic [31:0] word;
    logic [31:0] lower;
    logic [31:0] top;
    logic        hit;
    int          ones;
    word  = {2'b00, acc[31:2]};
    lower = 32'd0;
    if (!sel) begin
      return 1'b1;
    end
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      top  = {2'b00, shadow_addr[n]};
      ones = 0;
      while (ones < 30 && top[ones]) begin
        ones++;
      end
      case (iopmp_pkg::match_mode_e'(shadow_cfg[n][4:3]))
        iopmp_pkg::TOR:   hit = (word >= lower) && (word < top);
        iopmp_pkg::NA4:   hit = (word == top);
        iopmp_pkg::NAPOT: hit = (word >> (ones + 1)) == (top >> (ones + 1));
        default:          hit = 1'b0;
      endcase
      if (hit) begin
        return wr ? !shadow_cfg[n][1] : !shadow_cfg[n][0];
      end
      lower = top;  // TOR floor for the next entry
    end
    return 1'b1;
  endfunction

  // Mostly near region edges, sometimes anywhere
  function automatic logic [31:0] pick_addr();
    logic [31:0] r;
    int          k;
    r = $random(seed);
    k = $unsigned($random(seed)) % 10;
    if (r[1:0] == 2'b00) begin
      return $random(seed);
    end
    return edges[k] - 32'd16 + (r & 32'h1F);
  endfunction

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  task automatic expect_equal(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic csr_write(iopmp_pkg::csr_addr_t sel, logic [31:0] data);
    @(posedge cpuclk);
    csr_sel   <= sel;
    csr_wen   <= 1'b1;
    csr_wdata <= data;
    @(posedge cpuclk);
    csr_wen <= 1'b0;
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      if (!shadow_cfg[n][7] && sel == (n < 4 ? `IOPMP_CSR_PMPCFG0 : `IOPMP_CSR_PMPCFG1)) begin
        shadow_cfg[n] = data[(n % 4) * 8 +: 8] & 8'h9F;
      end
      if (!shadow_cfg[n][7] && sel == pmpaddr_sel(n)) begin
        shadow_addr[n] = data[29:0];
      end
    end
  endtask

  task automatic read_expect(iopmp_pkg::csr_addr_t sel, logic [31:0] exp);
    @(posedge cpuclk);
    csr_sel <= sel;
    @(negedge cpuclk);
    expect_equal($sformatf("csr_rdata at %h", sel), csr_rdata, exp);
  endtask

  task automatic compare_shadow();
    read_expect(`IOPMP_CSR_PMPCFG0,
                {shadow_cfg[3], shadow_cfg[2], shadow_cfg[1], shadow_cfg[0]});
    read_expect(`IOPMP_CSR_PMPCFG1,
                {shadow_cfg[7], shadow_cfg[6], shadow_cfg[5], shadow_cfg[4]});
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      read_expect(pmpaddr_sel(n), {2'b00, shadow_addr[n]});
    end
  endtask

  task automatic check_access(logic [31:0] a0, logic w0, logic [31:0] a1, logic w1);
    @(posedge cpuclk);
    addr_0  <= a0;
    write_0 <= w0;
    addr_1  <= a1;
    write_1 <= w1;
    @(negedge cpuclk);
    expect_equal($sformatf("deny_0 for %h", a0), 32'(deny_0),
                 32'(predict_deny(a0, w0, memory_domain_selected)));
    expect_equal($sformatf("deny_1 for %h", a1), 32'(deny_1),
                 32'(predict_deny(a1, w1, memory_domain_selected)));
  endtask

  task automatic wait_for_deny(string why);
    int cycles;
    cycles = 0;
    do begin
      @(negedge cpuclk);
      cycles++;
    end while (!(deny_0 && deny_1) && cycles < TIMEOUT_CYCLES);
    if (!(deny_0 && deny_1)) begin
      $display("Timeout: deny outputs never went high %s", why);
      $display("Test failed");
      $finish;
    end
  endtask

  task automatic finish_test(string name);
    test_errors += UUT.u_props.fail_count - prop_seen;  // Property failures in this test
    prop_seen    = UUT.u_props.fail_count;
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
      tests_bad++;
    end
    errors     += test_errors;
    test_errors = 0;
  endtask

  initial begin
    rst_n                  = 1'b0;
    memory_domain_selected = 1'b0;
    csr_sel                = '0;
    csr_wen                = 1'b0;
    csr_wdata              = '0;
    addr_0                 = '0;
    write_0                = 1'b0;
    addr_1                 = '0;
    write_1                = 1'b0;
    shadow_cfg             = '{default: '0};
    shadow_addr            = '{default: '0};
    repeat (8) @(posedge cpuclk);
    rst_n                  <= 1'b1;
    memory_domain_selected <= 1'b1;
    wait_for_deny("after reset");

    compare_shadow();  // Everything reads zero
    for (int i = 0; i < 8; i++) begin
      check_access($random(seed), 1'($random(seed)), $random(seed), 1'($random(seed)));
      expect_equal("deny_0 after reset", 32'(deny_0), 32'd1);
      expect_equal("deny_1 after reset", 32'(deny_1), 32'd1);
    end
    finish_test("reset values");

    // Overlapping regions, entries 6 and 7 locked
    csr_write(pmpaddr_sel(0), 32'h0000_0400);      // NA4 at 0x1000
    csr_write(pmpaddr_sel(1), 32'h0000_0800);      // TOR up to 0x2000
    csr_write(pmpaddr_sel(2), 32'h0000_06FF);      // NAPOT 2 KB at 0x1800
    csr_write(pmpaddr_sel(3), 32'h2000_1FFF);      // NAPOT 64 KB at 0x8000_0000
    csr_write(pmpaddr_sel(4), 32'h2400_0000);      // TOR up to 0x9000_0000
    csr_write(pmpaddr_sel(5), 32'hF000_0000);      // Top two bits dropped
    csr_write(pmpaddr_sel(6), 32'h3000_4000);
    csr_write(pmpaddr_sel(7), 32'h0000_0401);      // NA4 at 0x1004
    csr_write(`IOPMP_CSR_PMPCFG0, 32'h1F7A_0B11);  // Reserved bits set in entry 2
    csr_write(`IOPMP_CSR_PMPCFG1, 32'h928B_0009);
    compare_shadow();
    finish_test("program and read back");

    csr_write(`IOPMP_CSR_PMPCFG1, 32'h0000_0F09);  // Entry 5 becomes TOR
    csr_write(pmpaddr_sel(7), 32'hFFFF_FFFF);
    csr_write(pmpaddr_sel(6), 32'h0000_0000);
    compare_shadow();
    finish_test("lock");

    for (int i = 0; i < NUM_ACCESSES; i++) begin
      check_access(pick_addr(), 1'($random(seed)), pick_addr(), 1'($random(seed)));
    end
    finish_test("matching and priority");

    for (int i = 0; i < 12; i++) begin
      check_access(misses[i % 6], 1'(i), misses[(i + 1) % 6], 1'(i + 1));
      expect_equal("deny_0 outside regions", 32'(deny_0), 32'd1);
      expect_equal("deny_1 outside regions", 32'(deny_1), 32'd1);
    end
    finish_test("no hit");

    @(posedge cpuclk);
    memory_domain_selected <= 1'b0;
    wait_for_deny("while deselected");
    for (int i = 0; i < 20; i++) begin
      check_access(pick_addr(), 1'($random(seed)), pick_addr(), 1'($random(seed)));
    end
    @(posedge cpuclk);
    memory_domain_selected <= 1'b1;
    @(negedge cpuclk);
    finish_test("domain deselect");

    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- iopmp_props.sv
// IOPMP register and deselect properties
`include "iopmp_settings.svh"

module iopmp_props (
  input logic                                        cpuclk,
  input logic                                        rst_n,
  input logic                                        memory_domain_selected,
  input iopmp_pkg::csr_addr_t                        csr_sel,
  input logic                                        csr_wen,
  input logic                  [`IOPMP_XLEN-1:0]     csr_wdata,
  input logic                  [`IOPMP_XLEN-1:0]     csr_rdata,
  input iopmp_pkg::entry_cfg_t [`IOPMP_ENTRIES-1:0]  entry_cfg,
  input logic                                        deny_0,
  input logic                                        deny_1
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // Running total of property failures

  function automatic bit is_cfg(iopmp_pkg::csr_addr_t sel);
    return (sel == `IOPMP_CSR_PMPCFG0) || (sel == `IOPMP_CSR_PMPCFG1);
  endfunction

  // Entry behind a pmpaddr select, -1 for anything else
  function automatic int addr_entry(iopmp_pkg::csr_addr_t sel);
    int off;
    off = int'(sel) - int'(`IOPMP_CSR_PMPADDR0);
    if (off < 0 || off >= 4 * `IOPMP_ENTRIES || off[1:0] != 2'b00) begin
      return -1;
    end
    return off / 4;
  endfunction

  function automatic bit addr_lock_is(iopmp_pkg::csr_addr_t sel, bit locked,
                                      iopmp_pkg::entry_cfg_t [`IOPMP_ENTRIES-1:0] cfg);
    int n;
    n = addr_entry(sel);
    return (n >= 0) && (cfg[n].lock == locked);
  endfunction

  // Ones over every byte whose lock bit is clear
  function automatic logic [31:0] open_bytes(logic [31:0] old);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[b*8 +: 8] = old[b*8 + 7] ? 8'h00 : 8'hFF;
    end
    return m;
  endfunction

  ////////////////////////////////////////
  // Register write and lock
  ////////////////////////////////////////

  a_cfg_write: assert property (@(posedge cpuclk) disable iff (!rst_n)
    (csr_wen && is_cfg(csr_sel)) |=> (csr_sel != $past(csr_sel)) ||
      ((csr_rdata & open_bytes($past(csr_rdata))) ==
       ($past(csr_wdata) & 32'h9F9F_9F9F & open_bytes($past(csr_rdata)))))
    else begin
      fail_count++;
      $error("pmpcfg read-back does not show the written bytes");
    end

  a_cfg_lock: assert property (@(posedge cpuclk) disable iff (!rst_n)
    (csr_wen && is_cfg(csr_sel)) |=> (csr_sel != $past(csr_sel)) ||
      ((csr_rdata & ~open_bytes($past(csr_rdata))) ==
       ($past(csr_rdata) & ~open_bytes($past(csr_rdata)))))
    else begin
      fail_count++;
      $error("locked pmpcfg byte changed on a write");
    end

  a_addr_write: assert property (@(posedge cpuclk) disable iff (!rst_n)
    (csr_wen && addr_lock_is(csr_sel, 1'b0, entry_cfg)) |=>
      (csr_sel != $past(csr_sel)) || (csr_rdata == ($past(csr_wdata) & 32'h3FFF_FFFF)))
    else begin
      fail_count++;
      $error("pmpaddr read-back does not show the written value");
    end

  a_addr_lock: assert property (@(posedge cpuclk) disable iff (!rst_n)
    (csr_wen && addr_lock_is(csr_sel, 1'b1, entry_cfg)) |=>
      (csr_sel != $past(csr_sel)) || (csr_rdata == $past(csr_rdata)))
    else begin
      fail_count++;
      $error("locked pmpaddr changed on a write");
    end

  // Deselected domain blocks both ports
  a_deselect: assert property (@(posedge cpuclk) disable iff (!rst_n)
    !memory_domain_selected |-> (deny_0 && deny_1))
    else begin
      fail_count++;
      $error("access allowed while the domain is not selected");
    end

endmodule

bind iopmp_memory_domain iopmp_props u_props (
  .cpuclk                 (cpuclk                ),
  .rst_n                  (rst_n                 ),
  .memory_domain_selected (memory_domain_selected),
  .csr_sel                (csr_sel               ),
  .csr_wen                (csr_wen               ),
  .csr_wdata              (csr_wdata             ),
  .csr_rdata              (csr_rdata             ),
  .entry_cfg              (entry_cfg             ),
  .deny_0                 (deny_0                ),
  .deny_1                 (deny_1                )
);

//--- iopmp_memory_domain.sv
// IOPMP memory domain top
`include "iopmp_settings.svh"

module iopmp_memory_domain (
  input  logic                          cpuclk,
  input  logic                          rst_n,
  input  logic                          memory_domain_selected,
  input  iopmp_pkg::csr_addr_t          csr_sel,
  input  logic                          csr_wen,
  input  logic [`IOPMP_XLEN-1:0]        csr_wdata,
  output logic [`IOPMP_XLEN-1:0]        csr_rdata,
  input  logic [`IOPMP_XLEN-1:0]        addr_0,
  input  logic                          write_0,
  output logic                          deny_0,
  input  logic [`IOPMP_XLEN-1:0]        addr_1,
  input  logic                          write_1,
  output logic                          deny_1
);

  iopmp_pkg::entry_cfg_t  [`IOPMP_ENTRIES-1:0] entry_cfg;   // Shared by both ports
  iopmp_pkg::entry_addr_t [`IOPMP_ENTRIES-1:0] entry_addr;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  iopmp_csr_regs u_csr_regs (
    .cpuclk     (cpuclk    ),
    .rst_n      (rst_n     ),
    .csr_sel    (csr_sel   ),
    .csr_wen    (csr_wen   ),
    .csr_wdata  (csr_wdata ),
    .csr_rdata  (csr_rdata ),
    .entry_cfg  (entry_cfg ),
    .entry_addr (entry_addr)
  );

  ////////////////////////////////////////
  // Access ports
  ////////////////////////////////////////

  iopmp_port_check u_port_check_0 (
    .memory_domain_selected (memory_domain_selected),
    .entry_cfg              (entry_cfg             ),
    .entry_addr             (entry_addr            ),
    .acc_addr               (addr_0                ),
    .acc_write              (write_0               ),
    .deny                   (deny_0                )
  );

  iopmp_port_check u_port_check_1 (
    .memory_domain_selected (memory_domain_selected),
    .entry_cfg              (entry_cfg             ),
    .entry_addr             (entry_addr            ),
    .acc_addr               (addr_1                ),
    .acc_write              (write_1               ),
    .deny                   (deny_1                )
  );

endmodule

//--- iopmp_port_check.sv
// IOPMP permission check for one port
`include "iopmp_settings.svh"

module iopmp_port_check (
  input  logic                                         memory_domain_selected,
  input  iopmp_pkg::entry_cfg_t  [`IOPMP_ENTRIES-1:0]  entry_cfg,
  input  iopmp_pkg::entry_addr_t [`IOPMP_ENTRIES-1:0]  entry_addr,
  input  logic                   [`IOPMP_XLEN-1:0]     acc_addr,
  input  logic                                         acc_write,
  output logic                                         deny
);

  logic [`IOPMP_ENTRIES:0]   ge_chain;  // Bit n feeds entry n as its lower bound
  logic [`IOPMP_ENTRIES-1:0] hit;
  logic [`IOPMP_ENTRIES-1:0] allow;

  assign ge_chain[0] = 1'b1;  // Entry 0 TOR starts at address zero

  ////////////////////////////////////////
  // Per-entry match
  ////////////////////////////////////////

  for (genvar n = 0; n < `IOPMP_ENTRIES; n++) begin : g_entry
    iopmp_entry_match u_match (
      .mode       (entry_cfg[n].mode),
      .entry_addr (entry_addr[n]    ),
      .acc_addr   (acc_addr         ),
      .ge_prev    (ge_chain[n]      ),
      .ge_own     (ge_chain[n+1]    ),
      .hit        (hit[n]           )
    );

    assign allow[n] = acc_write ? entry_cfg[n].w : entry_cfg[n].r;
  end

  ////////////////////////////////////////
  // Priority decision
  ////////////////////////////////////////

  always_comb begin
    deny = 1'b1;  // No hit means deny
    // Walk down so the lowest hit entry wins
    for (int n = `IOPMP_ENTRIES - 1; n >= 0; n--) begin
      if (hit[n]) begin
        deny = !allow[n];
      end
    end
    if (!memory_domain_selected) begin
      deny = 1'b1;
    end
  end

endmodule

//--- iopmp_entry_match.sv
// IOPMP single entry address match
`include "iopmp_settings.svh"

module iopmp_entry_match (
  input  iopmp_pkg::match_mode_e          mode,
  input  iopmp_pkg::entry_addr_t          entry_addr,
  input  logic [`IOPMP_XLEN-1:0]          acc_addr,
  input  logic                            ge_prev,   // At or above previous boundary
  output logic                            ge_own,
  output logic                            hit
);

  iopmp_pkg::entry_addr_t acc_word;
  iopmp_pkg::entry_addr_t napot_low;
  iopmp_pkg::entry_addr_t napot_mask;

  assign acc_word = acc_addr[`IOPMP_XLEN-1:2];  // Word granule
  assign ge_own   = (acc_word >= entry_addr);

  // Trailing ones plus the first zero give the region size
  assign napot_low  = entry_addr ^ (entry_addr + 1'b1);
  assign napot_mask = ~napot_low;

  always_comb begin
    case (mode)
      iopmp_pkg::TOR:   hit = ge_prev && !ge_own;
      iopmp_pkg::NA4:   hit = (acc_word == entry_addr);
      iopmp_pkg::NAPOT: hit = ((acc_word ^ entry_addr) & napot_mask) == '0;
      default:          hit = 1'b0;  // OFF
    endcase
  end

endmodule

//--- iopmp_csr_regs.sv
// IOPMP configuration register block
`include "iopmp_settings.svh"

module iopmp_csr_regs (
  input  logic                                             cpuclk,
  input  logic                                             rst_n,
  input  iopmp_pkg::csr_addr_t                             csr_sel,
  input  logic                                             csr_wen,
  input  logic                  [`IOPMP_XLEN-1:0]          csr_wdata,
  output logic                  [`IOPMP_XLEN-1:0]          csr_rdata,
  output iopmp_pkg::entry_cfg_t [`IOPMP_ENTRIES-1:0]       entry_cfg,
  output iopmp_pkg::entry_addr_t [`IOPMP_ENTRIES-1:0]      entry_addr
);

  localparam int CFG_PER_REG = `IOPMP_XLEN / 8;              // Entry bytes per pmpcfg
  localparam int CFG_REGS    = `IOPMP_ENTRIES / CFG_PER_REG;

  logic [CFG_REGS-1:0]                         cfg_sel;
  logic [`IOPMP_ENTRIES-1:0]                   addr_sel;
  iopmp_pkg::entry_cfg_t [`IOPMP_ENTRIES-1:0]  cfg_wr;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign cfg_sel[0] = (csr_sel == `IOPMP_CSR_PMPCFG0);
  assign cfg_sel[1] = (csr_sel == `IOPMP_CSR_PMPCFG1);

  always_comb begin
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      addr_sel[n] = (csr_sel == iopmp_pkg::csr_addr_t'(`IOPMP_CSR_PMPADDR0 + 4 * n));
    end
  end

  // Byte of the write word that lands in each entry
  always_comb begin
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      cfg_wr[n]          = csr_wdata[(n % CFG_PER_REG) * 8 +: 8];
      cfg_wr[n].reserved = 2'b00;  // Hardwired zero
    end
  end

  ////////////////////////////////////////
  // Storage with lock
  ////////////////////////////////////////

  always_ff @(posedge cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      entry_cfg  <= '0;  // All entries OFF, unlocked
      entry_addr <= '0;
    end else if (csr_wen) begin
      for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
        // A locked entry holds both its byte and its address
        if (cfg_sel[n / CFG_PER_REG] && !entry_cfg[n].lock) begin
          entry_cfg[n] <= cfg_wr[n];
        end
        if (addr_sel[n] && !entry_cfg[n].lock) begin
          entry_addr[n] <= csr_wdata[`IOPMP_XLEN-3:0];  // Bits 31:30 dropped
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////

  always_comb begin
    csr_rdata = '0;  // Unknown addresses read zero
    for (int c = 0; c < CFG_REGS; c++) begin
      if (cfg_sel[c]) begin
        csr_rdata = entry_cfg[c * CFG_PER_REG +: CFG_PER_REG];
      end
    end
    for (int n = 0; n < `IOPMP_ENTRIES; n++) begin
      if (addr_sel[n]) begin
        csr_rdata = {2'b00, entry_addr[n]};
      end
    end
  end

endmodule

//--- iopmp_pkg.sv
// IOPMP shared types
`include "iopmp_settings.svh"

package iopmp_pkg;

  // CSR select as driven on the register port
  typedef logic [11:0] csr_addr_t;

  // Address in 4-byte units, matches access bits 31:2
  typedef logic [`IOPMP_XLEN-3:0] entry_addr_t;

  // Entry match mode
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } match_mode_e;

  // One configuration byte, top bit first
  typedef struct packed {
    logic        lock;
    logic [1:0]  reserved;  // Always reads zero
    match_mode_e mode;
    logic        x;         // Kept for read-back only
    logic        w;
    logic        r;
  } entry_cfg_t;

endpackage

//--- iopmp_settings.svh
// IOPMP configuration constants
`ifndef IOPMP_SETTINGS_SVH
`define IOPMP_SETTINGS_SVH

////////////////////////////////////////
// Sizing
////////////////////////////////////////

// Protection entries in one memory domain
`define IOPMP_ENTRIES 8

// Access address and CSR data width
`define IOPMP_XLEN 32

////////////////////////////////////////
// CSR map
////////////////////////////////////////

// Config registers, four entry bytes each
`define IOPMP_CSR_PMPCFG0 12'h3A0
`define IOPMP_CSR_PMPCFG1 12'h3A4

// Entry n address register sits at this base plus 4n
`define IOPMP_CSR_PMPADDR0 12'h3B0

`endif
